// ==== Makefile ====
SIM        ?= verilator
TOP        ?= cpu_tb
RTL_TOP    ?= cpu_top
FILELIST   ?= cr16.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   := SIMULATION PASSED

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== cr16.f ====
source/cr16_pkg.sv
source/flopenr.sv
source/regfile.sv
source/alu.sv
source/datapath.sv
source/controller.sv
source/cpu_top.sv
tb/cpu_tb.sv

// ==== source/alu.sv ====
`timescale 1ns/1ns

module alu (
	input  cr16_pkg::word_t   a,
	input  cr16_pkg::word_t   b,
	input  cr16_pkg::alu_op_t op,
	output cr16_pkg::word_t   result,
	output cr16_pkg::psr_t    flags
);

	logic [16:0] sum;                             // Bit 16 is the carry out
	logic [16:0] diff;                            // Bit 16 is the borrow
	logic        add_ovf;
	logic        sub_ovf;

	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b};

	// Signed overflow when operand signs predict a different result sign
	assign add_ovf = (a[15] == b[15]) && (sum[15] != a[15]);
	assign sub_ovf = (a[15] != b[15]) && (diff[15] != a[15]);

	always_comb begin
		unique case (op)
			cr16_pkg::ALU_ADD:   result = sum[15:0];
			cr16_pkg::ALU_SUB:   result = diff[15:0];
			cr16_pkg::ALU_AND:   result = a & b;
			cr16_pkg::ALU_OR:    result = a | b;
			cr16_pkg::ALU_XOR:   result = a ^ b;
			cr16_pkg::ALU_PASSB: result = b;       // MOV and MOVI
			cr16_pkg::ALU_LUI:   result = {b[7:0], a[7:0]};  // Keeps low byte of A
			default:             result = '0;
		endcase
	end

	always_comb begin
		flags = '0;
		case (op)
			cr16_pkg::ALU_ADD: begin
				flags.carry    = sum[16];
				flags.overflow = add_ovf;
			end
			cr16_pkg::ALU_SUB: begin
				flags.carry    = diff[16];     // Borrow out of A minus B
				flags.overflow = sub_ovf;
			end
			default: begin
				flags.carry    = 1'b0;
				flags.overflow = 1'b0;
			end
		endcase
		// Compare flags always taken from A minus B
		flags.low      = a < b;
		flags.zero     = (diff[15:0] == 16'd0);
		flags.negative = diff[15];
	end

endmodule

// ==== source/controller.sv ====
`timescale 1ns/1ns

module controller (
	input  logic             clk,
	input  logic             rst_n,
	input  cr16_pkg::instr_t instr,
	input  logic             branch_taken,
	output cr16_pkg::ctrl_t  ctrl
);

	typedef enum logic [1:0] {S_FETCH, S_DECODE, S_EXECUTE, S_MEMORY} state_t;

	state_t state;
	state_t state_next;
	logic   is_load;
	logic   is_stor;

	assign is_load = (instr.op == cr16_pkg::OP_SPECIAL) && (instr.ext == cr16_pkg::EXT_LOAD);
	assign is_stor = (instr.op == cr16_pkg::OP_SPECIAL) && (instr.ext == cr16_pkg::EXT_STOR);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= S_FETCH;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = S_FETCH;
		case (state)
			S_FETCH:   state_next = S_DECODE;
			S_DECODE:  state_next = S_EXECUTE;
			S_EXECUTE: state_next = (is_load || is_stor) ? S_MEMORY : S_FETCH;
			default:   state_next = S_FETCH;      // MEMORY always returns
		endcase
	end

	always_comb begin
		ctrl        = '0;
		ctrl.a_sel  = cr16_pkg::A_REG;
		ctrl.b_sel  = cr16_pkg::B_REG;
		ctrl.pc_sel = cr16_pkg::PC_INC;
		ctrl.wb_sel = cr16_pkg::WB_ALU;
		ctrl.alu_op = cr16_pkg::ALU_ADD;
		case (state)
			S_FETCH: begin
				ctrl.instruction_en = 1'b1;   // Word at PC into IR
				ctrl.pc_en          = 1'b1;   // PC steps past it
			end
			S_EXECUTE: begin
				case (instr.op)
					cr16_pkg::OP_RTYPE: begin
						case (instr.ext)
							cr16_pkg::EXT_ADD: begin
								ctrl.reg_write = 1'b1;
								ctrl.flags_en  = 1'b1;
							end
							cr16_pkg::EXT_SUB: begin
								ctrl.alu_op    = cr16_pkg::ALU_SUB;
								ctrl.reg_write = 1'b1;
								ctrl.flags_en  = 1'b1;
							end
							cr16_pkg::EXT_CMP: begin
								ctrl.alu_op   = cr16_pkg::ALU_SUB;
								ctrl.flags_en = 1'b1;  // Flags only
							end
							cr16_pkg::EXT_AND: begin
								ctrl.alu_op    = cr16_pkg::ALU_AND;
								ctrl.reg_write = 1'b1;
							end
							cr16_pkg::EXT_OR: begin
								ctrl.alu_op    = cr16_pkg::ALU_OR;
								ctrl.reg_write = 1'b1;
							end
							cr16_pkg::EXT_XOR: begin
								ctrl.alu_op    = cr16_pkg::ALU_XOR;
								ctrl.reg_write = 1'b1;
							end
							cr16_pkg::EXT_MOV: begin
								ctrl.alu_op    = cr16_pkg::ALU_PASSB;
								ctrl.reg_write = 1'b1;
							end
							default: ;            // Unknown ext is a no-op
						endcase
					end
					cr16_pkg::OP_ADDI: begin
						ctrl.b_sel     = cr16_pkg::B_IMM;
						ctrl.reg_write = 1'b1;
						ctrl.flags_en  = 1'b1;
					end
					cr16_pkg::OP_SUBI, cr16_pkg::OP_CMPI: begin
						ctrl.b_sel     = cr16_pkg::B_IMM;
						ctrl.alu_op    = cr16_pkg::ALU_SUB;
						ctrl.flags_en  = 1'b1;
						ctrl.reg_write = (instr.op == cr16_pkg::OP_SUBI);  // CMPI keeps A
					end
					cr16_pkg::OP_MOVI, cr16_pkg::OP_LUI: begin
						ctrl.b_sel     = cr16_pkg::B_IMM;
						ctrl.alu_op    = (instr.op == cr16_pkg::OP_LUI) ? cr16_pkg::ALU_LUI
						                                               : cr16_pkg::ALU_PASSB;
						ctrl.reg_write = 1'b1;
					end
					cr16_pkg::OP_SPECIAL: begin
						if (instr.ext == cr16_pkg::EXT_JAL) begin
							ctrl.wb_sel    = cr16_pkg::WB_PC;  // Return address into A
							ctrl.reg_write = 1'b1;
							ctrl.pc_sel    = cr16_pkg::PC_REGB;
							ctrl.pc_en     = 1'b1;
						end
					end
					cr16_pkg::OP_BCOND: begin
						ctrl.a_sel  = cr16_pkg::A_PC;  // PC plus displacement
						ctrl.b_sel  = cr16_pkg::B_IMM;
						ctrl.pc_sel = cr16_pkg::PC_ALU;
						ctrl.pc_en  = branch_taken;
					end
					default: ;                    // Unknown op only advanced the PC
				endcase
			end
			S_MEMORY: begin
				ctrl.mem_access = 1'b1;       // Address from B latch
				ctrl.mem_we     = is_stor;
				ctrl.reg_write  = is_load;
				ctrl.wb_sel     = cr16_pkg::WB_MEM;
			end
			default: ;                            // DECODE only latches operands
		endcase
	end

endmodule

// ==== source/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top (
	input  logic            clk,
	input  logic            rst_n,
	output cr16_pkg::word_t mem_addr,
	output cr16_pkg::word_t mem_wdata,
	output logic            mem_we,
	input  cr16_pkg::word_t mem_rdata,
	output cr16_pkg::psr_t  psr_flags
);

	cr16_pkg::ctrl_t  ctrl;                       // Controller to datapath
	cr16_pkg::instr_t instr;                      // Latched instruction back
	logic             branch_taken;

	controller ctl (
		.clk(clk), .rst_n(rst_n), .instr(instr), .branch_taken(branch_taken), .ctrl(ctrl)
	);

	datapath dp (
		.clk(clk), .rst_n(rst_n), .ctrl(ctrl), .mem_rdata(mem_rdata), .instr(instr),
		.branch_taken(branch_taken), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.psr_flags(psr_flags)
	);

	assign mem_we = ctrl.mem_we;                  // One cycle in MEMORY for STOR

endmodule

// ==== source/cr16_pkg.sv ====
package cr16_pkg;

	typedef logic [15:0] word_t;                  // Data word and memory address

	typedef struct packed {
		logic [3:0] op;                       // Bits 15 to 12
		logic [3:0] reg_a;                    // Destination or condition
		logic [3:0] ext;                      // Extended op or upper immediate nibble
		logic [3:0] reg_b;                    // Source or lower immediate nibble
	} instr_t;

	typedef struct packed {
		logic carry;
		logic low;                            // Unsigned A below B
		logic overflow;
		logic zero;
		logic negative;
	} psr_t;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASSB, ALU_LUI
	} alu_op_t;

	typedef enum logic {A_PC, A_REG} a_sel_t;     // ALU first input
	typedef enum logic {B_REG, B_IMM} b_sel_t;    // ALU second input
	typedef enum logic [1:0] {PC_ALU, PC_REGB, PC_INC} pc_sel_t;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC} wb_sel_t;

	typedef struct packed {
		logic    instruction_en;              // Load instruction register
		logic    pc_en;
		logic    reg_write;
		logic    flags_en;
		logic    mem_access;                  // Address from register B
		logic    mem_we;
		alu_op_t alu_op;
		a_sel_t  a_sel;
		b_sel_t  b_sel;
		pc_sel_t pc_sel;
		wb_sel_t wb_sel;
	} ctrl_t;

	localparam logic [3:0] OP_RTYPE   = 4'h0;     // Register to register group
	localparam logic [3:0] OP_SPECIAL = 4'h4;     // LOAD, STOR, JAL
	localparam logic [3:0] OP_ADDI    = 4'h5;
	localparam logic [3:0] OP_SUBI    = 4'h9;
	localparam logic [3:0] OP_CMPI    = 4'hB;
	localparam logic [3:0] OP_BCOND   = 4'hC;
	localparam logic [3:0] OP_MOVI    = 4'hD;
	localparam logic [3:0] OP_LUI     = 4'hF;

	localparam logic [3:0] EXT_AND  = 4'h1;
	localparam logic [3:0] EXT_OR   = 4'h2;
	localparam logic [3:0] EXT_XOR  = 4'h3;
	localparam logic [3:0] EXT_ADD  = 4'h5;
	localparam logic [3:0] EXT_SUB  = 4'h9;
	localparam logic [3:0] EXT_CMP  = 4'hB;
	localparam logic [3:0] EXT_MOV  = 4'hD;
	localparam logic [3:0] EXT_LOAD = 4'h0;       // Under OP_SPECIAL
	localparam logic [3:0] EXT_STOR = 4'h4;
	localparam logic [3:0] EXT_JAL  = 4'h8;

	localparam logic [3:0] COND_EQ = 4'h0;        // Condition held in the A field
	localparam logic [3:0] COND_NE = 4'h1;

endpackage

// ==== source/datapath.sv ====
`timescale 1ns/1ns

module datapath (
	input  logic             clk,
	input  logic             rst_n,
	input  cr16_pkg::ctrl_t  ctrl,
	input  cr16_pkg::word_t  mem_rdata,
	output cr16_pkg::instr_t instr,
	output logic             branch_taken,
	output cr16_pkg::word_t  mem_addr,
	output cr16_pkg::word_t  mem_wdata,
	output cr16_pkg::psr_t   psr_flags
);

	cr16_pkg::word_t pc;
	cr16_pkg::word_t pc_inc;                      // Address of the next word
	cr16_pkg::word_t pc_next;
	cr16_pkg::word_t a_data;                      // Register file read ports
	cr16_pkg::word_t b_data;
	cr16_pkg::word_t a_reg;                       // Operand latches
	cr16_pkg::word_t b_reg;
	cr16_pkg::word_t imm;
	cr16_pkg::word_t alu_a;
	cr16_pkg::word_t alu_b;
	cr16_pkg::word_t alu_result;
	cr16_pkg::word_t write_data;
	cr16_pkg::psr_t  alu_flags;

	flopenr #(.T(cr16_pkg::instr_t)) ir_reg (
		.clk(clk), .rst_n(rst_n), .en(ctrl.instruction_en),
		.d(cr16_pkg::instr_t'(mem_rdata)), .q(instr)
	);

	flopenr #(.T(cr16_pkg::word_t)) pc_reg (
		.clk(clk), .rst_n(rst_n), .en(ctrl.pc_en), .d(pc_next), .q(pc)
	);

	flopenr #(.T(cr16_pkg::psr_t)) psr_reg (
		.clk(clk), .rst_n(rst_n), .en(ctrl.flags_en), .d(alu_flags), .q(psr_flags)
	);

	regfile rf (
		.clk(clk), .rst_n(rst_n), .reg_write(ctrl.reg_write),
		.a_index(instr.reg_a), .b_index(instr.reg_b), .write_data(write_data),
		.a_data(a_data), .b_data(b_data)
	);

	always_ff @(posedge clk) begin
		a_reg <= a_data;                      // Stable from DECODE through MEMORY
		b_reg <= b_data;
	end

	assign pc_inc = pc + 16'd1;
	assign imm    = {{8{instr.ext[3]}}, instr.ext, instr.reg_b};  // Sign-extended 7..0

	assign alu_a = (ctrl.a_sel == cr16_pkg::A_PC) ? pc : a_reg;
	assign alu_b = (ctrl.b_sel == cr16_pkg::B_IMM) ? imm : b_reg;

	alu alu_unit (.a(alu_a), .b(alu_b), .op(ctrl.alu_op), .result(alu_result), .flags(alu_flags));

	always_comb begin
		case (ctrl.pc_sel)
			cr16_pkg::PC_ALU:  pc_next = alu_result;  // Branch target
			cr16_pkg::PC_REGB: pc_next = b_reg;       // JAL target
			default:           pc_next = pc_inc;
		endcase
		case (ctrl.wb_sel)
			cr16_pkg::WB_MEM: write_data = mem_rdata;
			cr16_pkg::WB_PC:  write_data = pc;        // PC already points past JAL
			default:          write_data = alu_result;
		endcase
	end

	assign mem_addr  = ctrl.mem_access ? b_reg : pc;
	assign mem_wdata = ctrl.mem_we ? a_reg : '0;      // Zero outside a store

	// Condition from the A field tested against the stored zero flag
	assign branch_taken = (instr.reg_a == cr16_pkg::COND_EQ && psr_flags.zero) ||
	                      (instr.reg_a == cr16_pkg::COND_NE && !psr_flags.zero);

endmodule

// ==== source/flopenr.sv ====
`timescale 1ns/1ns

module flopenr #(
	parameter type T = logic
) (
	input  logic clk,
	input  logic rst_n,
	input  logic en,                              // Load strobe
	input  T     d,
	output T     q
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			q <= '0;                      // Clear whole payload
		else if (en)
			q <= d;
	end

endmodule

// ==== source/regfile.sv ====
`timescale 1ns/1ns

module regfile (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             reg_write,
	input  logic [3:0]       a_index,         // Read port A and write address
	input  logic [3:0]       b_index,
	input  cr16_pkg::word_t  write_data,
	output cr16_pkg::word_t  a_data,
	output cr16_pkg::word_t  b_data
);

	cr16_pkg::word_t regs [16];                   // Entry 0 never written

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			regs <= '{default: '0};       // All registers start at zero
		else if (reg_write && a_index != 4'd0)
			regs[a_index] <= write_data;  // Writes to r0 dropped
	end

	always_comb begin
		a_data = (a_index == 4'd0) ? '0 : regs[a_index];  // r0 reads as zero
		b_data = (b_index == 4'd0) ? '0 : regs[b_index];
	end

endmodule

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb;

	localparam int IMAGE_WORDS = 64;                       // Program and data image
	localparam int NUM_TESTS   = 6;                        // Last one checks the flags
	localparam int WATCHDOG_NS = IMAGE_WORDS * 4 * 8 * 10; // Words x cycles x passes x period

	logic             clk;
	logic             rst_n;
	cr16_pkg::word_t  mem_addr;
	cr16_pkg::word_t  mem_wdata;
	logic             mem_we;
	cr16_pkg::word_t  mem_rdata;
	cr16_pkg::psr_t   psr_flags;

	cr16_pkg::word_t  testdata [128];                      // Image, counts, store records
	cr16_pkg::word_t  mem [IMAGE_WORDS];
	cr16_pkg::word_t  expected_stores;
	cr16_pkg::word_t  store_count;
	logic [6:0]       rec;                                 // Next expected record
	logic             done;
	int               test_errors [8];
	int               tests_passed;
	int               tests_failed;
	int               extra_stores;

	cpu_top UUT (
		.clk(clk), .rst_n(rst_n), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_we(mem_we), .mem_rdata(mem_rdata), .psr_flags(psr_flags)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;                         // 10 ns period
	end

	// Same cycle read, nothing mapped above the image
	assign mem_rdata = (mem_addr[15:6] == 10'd0) ? mem[mem_addr[5:0]] : '0;

	always @(posedge clk) begin
		if (rst_n && mem_we && mem_addr[15:6] == 10'd0)
			mem[mem_addr[5:0]] <= mem_wdata;       // Store lands on the rising edge
	end

	task automatic report_test(input logic [2:0] id);
		if (test_errors[id] == 0) begin
			tests_passed++;
			$display("Test %0d passed", id);
		end else begin
			tests_failed++;
			$display("Test %0d failed with %0d errors", id, test_errors[id]);
		end
	endtask

	task automatic print_counts();
		$display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
	endtask

	task automatic check_flags();
		assert (psr_flags == testdata[65][4:0]) else begin
			$display("Fail test 6: psr_flags expected %h, got %h",
			         testdata[65][4:0], psr_flags);
			test_errors[6]++;
		end
		report_test(3'd6);
	endtask

	task automatic check_store();
		logic [2:0] id;
		id = testdata[rec][2:0];                       // Test number of this record
		assert (mem_addr == testdata[rec + 7'd1]) else begin
			$display("Fail test %0d store %0d: mem_addr expected %h, got %h",
			         id, store_count, testdata[rec + 7'd1], mem_addr);
			test_errors[id]++;
		end
		assert (mem_wdata == testdata[rec + 7'd2]) else begin
			$display("Fail test %0d store %0d: mem_wdata expected %h, got %h",
			         id, store_count, testdata[rec + 7'd2], mem_wdata);
			test_errors[id]++;
		end
		store_count++;
		rec = rec + 7'd3;
		if (store_count == expected_stores) begin
			report_test(id);
			check_flags();                         // Final compare already retired
			done = 1'b1;
		end else if (testdata[rec][2:0] != id) begin
			report_test(id);                       // Next record opens another test
		end
	endtask

	always @(negedge clk) begin
		if (rst_n && mem_we) begin
			assert (store_count < expected_stores) else begin
				$display("Unexpected store to address %h after all %0d expected stores",
				         mem_addr, expected_stores);
				extra_stores++;
			end
			if (store_count < expected_stores)
				check_store();
		end
	end

	initial begin
		rst_n        = 1'b0;
		done         = 1'b0;
		store_count  = '0;
		rec          = 7'd66;                          // First store record
		tests_passed = 0;
		tests_failed = 0;
		extra_stores = 0;
		test_errors  = '{default: 0};
		$readmemh("tb/cpu_testdata.mem", testdata);
		expected_stores = testdata[64];
		for (int i = 0; i < IMAGE_WORDS; i++)
			mem[i[5:0]] <= testdata[i[6:0]];
		repeat (3) @(posedge clk);                     // Three cycles in reset
		@(negedge clk);
		rst_n = 1'b1;
		wait (done);
		repeat (10) @(negedge clk);                    // Window for stray stores
		print_counts();
		if (tests_failed == 0 && extra_stores == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout after %0d ns, %0d of %0d expected stores never arrived",
		         WATCHDOG_NS, expected_stores - store_count, expected_stores);
		tests_failed = NUM_TESTS - tests_passed;       // Unfinished tests count as failed
		print_counts();
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== tb/cpu_testdata.mem ====
// Words 0-63 program and data image, word 64 store count, word 65 final psr flags
// Then one record per store, columns are test number, store address, store data
DF3F D15A D2F3 03D1 434F 0352 434F 0391
434F 0311 434F 0332 434F 0321 434F D410
54FD 444F 94F0 444F D59C F53B 454F D638
4706 D83A 4748 5601 4906 494F D055 4048
B15A C102 414F C001 424F 434F 01B2 C001
444F C101 424F 454F DB00 5B01 BB04 C1FD
4B4F DD36 4E8D 0BB4 4C4F C1FF 4E4F 4C8E
BEEF 0C1A 0000 0000 0000 0000 0000 0000
0013 0019
// Register operations
0001 003F 005A 0001 003F 004D 0001 003F FFF3
0001 003F 0052 0001 003F FFA1 0001 003F FFFB
// Immediate operations
0002 003F 000D 0002 003F 001D 0002 003F 3B9C
// Loads stored back, then r0 after a write to it
0003 003A BEEF 0003 003F 0C1A 0003 003A 0000
// Branch path markers and loop counter
0004 003F 005A 0004 003F FFFB 0004 003F 001D
0004 003F 3B9C 0004 003F 0004
// Return address of the call and the scratch link
0005 003F 0033 0005 003F 0038
